// File: Bender.yml
package:
  name: sdmac_regs

sources:
  - common/sdmac_bus_pkg.sv
  - common/sdmac_reg_pkg.sv
  - fifo/dma_fifo.sv
  - registers/cntr_reg.sv
  - registers/istr_reg.sv
  - registers/addr_counter.sv
  - verilog/reg_access.sv
  - verilog/sdmac_regs_top.sv
  - target: test
    files:
      - verif/tb_sdmac_regs.sv

// File: all.f
common/sdmac_bus_pkg.sv
common/sdmac_reg_pkg.sv
fifo/dma_fifo.sv
registers/cntr_reg.sv
registers/istr_reg.sv
registers/addr_counter.sv
verilog/reg_access.sv
verilog/sdmac_regs_top.sv
verif/tb_sdmac_regs.sv

// File: common/sdmac_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDMAC bus package
// Host access and DMA data types used on the bus side
// of the register block and the word FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sdmac_bus_pkg;

  // Host data path width
  localparam int DATA_W = 32;

  // Byte offset width, covers 0x00 to 0x1F
  localparam int ADDR_W = 5;

  // One host access
  // rd and wr are single-cycle pulses, never high together
  typedef struct packed {
    logic              rd;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } host_req_t;

  // Read response
  // rd_valid is high for one cycle, the cycle after rd
  typedef struct packed {
    logic              rd_valid;
    logic [DATA_W-1:0] rd_data;
  } host_rsp_t;

  // One DMA word as held in the FIFO
  typedef logic [DATA_W-1:0] dma_word_t;

endpackage : sdmac_bus_pkg

// File: common/sdmac_reg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDMAC register package
// Register offsets, CNTR and ISTR field layouts and
// the decoder strobe bundle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package sdmac_reg_pkg;

  // Register byte offsets
  localparam logic [4:0] CNTR_ADDR    = 5'h08;
  localparam logic [4:0] ACR_ADDR     = 5'h0C;
  localparam logic [4:0] CLR_INT_ADDR = 5'h14;
  localparam logic [4:0] ISTR_ADDR    = 5'h1C;

  // CNTR fields, low bits of the data word
  // intena in bit 0, dir in bit 1
  typedef struct packed {
    logic dir;
    logic intena;
  } cntr_t;

  // ISTR, 9 bits, high bit first
  typedef struct packed {
    logic       rsvd_hi;
    // Sticky interrupt flags
    logic       int_f;
    logic       ints;
    logic       e_int;
    logic       int_p;
    logic [1:0] rsvd_lo;
    // FIFO full and empty as sampled on read
    logic       ff;
    logic       fe;
  } istr_t;

  // Decoder outputs, at most one high per cycle
  typedef struct packed {
    logic cntr_wr;
    logic acr_wr;
    logic clr_int;
    logic istr_rd;
  } reg_strobe_t;

endpackage : sdmac_reg_pkg

// File: fifo/dma_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA word FIFO
// Show-ahead circular buffer with full and empty
// flags and a transfer pulse per accepted access
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dma_fifo #(
  // Number of words, power of two
  parameter int FIFO_DEPTH = 8
) (
  input  logic                     clk,
  input  logic                     RESET_,
  input  logic                     push,
  input  sdmac_bus_pkg::dma_word_t push_data,
  input  logic                     pop,
  output sdmac_bus_pkg::dma_word_t pop_data,
  output logic                     full,
  output logic                     empty,
  output logic                     xfer
);

  import sdmac_bus_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  // Count needs one more bit to reach FIFO_DEPTH
  localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W+1)'(FIFO_DEPTH);

  dma_word_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push_ok;
  logic             pop_ok;

  assign full  = (count == DEPTH_CNT);
  assign empty = (count == '0);

  // Push while full is dropped, pop while empty is ignored
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;

  // One pulse per cycle with any accepted access
  // a push and pop in the same cycle give one pulse
  assign xfer = push_ok | pop_ok;

  // Storage, no reset on the data
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap naturally with a power-of-two depth
  always_ff @(posedge clk) begin
    if (!RESET_) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy, unchanged when both sides move
  always_ff @(posedge clk) begin
    if (!RESET_) begin
      count <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head word is always visible
  assign pop_data = mem[rd_ptr];

  // Occupancy stays within the buffer
  a_count_bound: assert property (@(posedge clk) disable iff (!RESET_)
    count <= DEPTH_CNT);

endmodule : dma_fifo

// File: registers/addr_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA address counter
// Loaded by the host, advances one step for every
// accepted FIFO transfer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module addr_counter #(
  // Byte step per transferred word
  parameter int ACR_STEP = 4
) (
  input  logic                             clk,
  input  logic                             RESET_,
  input  logic                             acr_wr,
  input  logic [sdmac_bus_pkg::DATA_W-1:0] wdata,
  input  logic                             xfer,
  output logic [sdmac_bus_pkg::DATA_W-1:0] acr
);

  // Step sized to the counter
  localparam logic [$bits(acr)-1:0] STEP = ACR_STEP;

  logic [$bits(acr)-1:0] acr_q;

  // Host load wins over a transfer in the same cycle
  always_ff @(posedge clk) begin
    if (!RESET_) begin
      acr_q <= '0;
    end else if (acr_wr) begin
      acr_q <= wdata;
    end else if (xfer) begin
      // Wraps at the top of the address space
      acr_q <= acr_q + STEP;
    end
  end

  assign acr = acr_q;

endmodule : addr_counter

// File: registers/cntr_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control register
// Holds interrupt enable and transfer direction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module cntr_reg (
  input  logic                             clk,
  input  logic                             RESET_,
  input  logic                             cntr_wr,
  input  logic [sdmac_bus_pkg::DATA_W-1:0] wdata,
  output sdmac_reg_pkg::cntr_t             cntr
);

  import sdmac_reg_pkg::*;

  cntr_t cntr_q;

  // Only the defined fields are kept
  // upper write bits are dropped and read back as zero
  always_ff @(posedge clk) begin
    if (!RESET_) begin
      cntr_q <= '0;
    end else if (cntr_wr) begin
      cntr_q <= wdata[$bits(cntr_t)-1:0];
    end
  end

  // intena feeds the interrupt gate, dir the DMA side
  assign cntr = cntr_q;

endmodule : cntr_reg

// File: registers/istr_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt status register
// Sticky interrupt flags, FIFO status sampled on
// read and the active-low interrupt output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module istr_reg (
  input  logic                 clk,
  input  logic                 RESET_,
  input  logic                 clr_int,
  input  logic                 istr_rd,
  input  logic                 intena,
  input  logic                 int_a,
  input  logic                 full,
  input  logic                 empty,
  output sdmac_reg_pkg::istr_t istr,
  output logic                 int_n
);

  import sdmac_reg_pkg::*;

  logic int_f_q;
  logic ints_q;
  logic e_int_q;
  logic int_p_q;
  logic ff_q;
  logic fe_q;

  // Flags hold until CLR_INT, clear wins over a new set
  always_ff @(posedge clk) begin
    if (!RESET_ || clr_int) begin
      int_f_q <= 1'b0;
      ints_q  <= 1'b0;
      e_int_q <= 1'b0;
      int_p_q <= 1'b0;
    end else begin
      int_f_q <= int_f_q | int_a;
      ints_q  <= ints_q  | int_a;
      e_int_q <= e_int_q | int_a;
      // Pending only when the interrupt is enabled
      int_p_q <= int_p_q | (int_a & intena);
    end
  end

  // FIFO status captured on the ISTR read edge
  always_ff @(posedge clk) begin
    if (!RESET_) begin
      ff_q <= 1'b0;
      fe_q <= 1'b1;
    end else if (istr_rd) begin
      ff_q <= full;
      fe_q <= empty;
    end
  end

  // Status word
  // During the read cycle the live FIFO flags are shown so the
  // decoder captures the same values the sample registers take
  always_comb begin
    istr         = '0;
    istr.int_f   = int_f_q;
    istr.ints    = ints_q;
    istr.e_int   = e_int_q;
    istr.int_p   = int_p_q;
    istr.ff      = istr_rd ? full  : ff_q;
    istr.fe      = istr_rd ? empty : fe_q;
  end

  // Interrupt follows registered enable and live request
  assign int_n = ~(intena & int_a);

  // A disabled interrupt never reaches the host
  a_int_gated: assert property (@(posedge clk) disable iff (!RESET_)
    !intena |-> int_n);

endmodule : istr_reg

// File: verif/tb_sdmac_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDMAC register block testbench
// Reference model of CNTR, ACR, ISTR flags and FIFO
// with a compare process, typed checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_sdmac_regs;

  timeunit 1ns;
  timeprecision 100ps;

  import sdmac_bus_pkg::*;
  import sdmac_reg_pkg::*;

  localparam int FIFO_DEPTH     = 8;
  localparam int ACR_STEP       = 4;
  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int NUM_TESTS      = 6;
  localparam int TIMEOUT_CYCLES = 200 * NUM_TESTS + RESET_CYCLES;
  localparam logic [31:0] SEED  = 32'hf629641b;

  logic      clk = 1'b0;
  logic      RESET_;
  host_req_t host_req;
  host_rsp_t host_rsp;
  logic      int_a;
  logic      int_n;
  logic      push;
  dma_word_t push_data;
  logic      pop;
  dma_word_t pop_data;
  logic      full;
  logic      empty;
  dma_word_t dma_addr;

  // Reference model state
  cntr_t     m_cntr;
  dma_word_t m_acr;
  logic      m_int_f;
  logic      m_ints;
  logic      m_e_int;
  logic      m_int_p;
  dma_word_t m_fifo[$];

  // Expected read words, queued at the rd pulse
  dma_word_t         exp_rd_q[$];
  logic [ADDR_W-1:0] exp_addr_q[$];

  int error_count  = 0;
  int check_count  = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  sdmac_regs_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .ACR_STEP   (ACR_STEP)
  ) uut (
    .clk       (clk),
    .RESET_    (RESET_),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .int_a     (int_a),
    .int_n     (int_n),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty),
    .dma_addr  (dma_addr)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ISTR as the plan lays it out
  // FIFO bits reflect the live state in the read cycle
  function automatic istr_t expected_istr();
    istr_t r;
    r       = '0;
    r.int_f = m_int_f;
    r.ints  = m_ints;
    r.e_int = m_e_int;
    r.int_p = m_int_p;
    r.ff    = (m_fifo.size() == FIFO_DEPTH);
    r.fe    = (m_fifo.size() == 0);
    return r;
  endfunction

  // Word the host should see for a read of this offset
  function automatic dma_word_t expected_read(input logic [ADDR_W-1:0] addr);
    case (addr)
      CNTR_ADDR: return {30'b0, m_cntr.dir, m_cntr.intena};
      ACR_ADDR:  return m_acr;
      ISTR_ADDR: return {23'b0, expected_istr()};
      // CLR_INT and unmapped offsets read zero
      default:   return '0;
    endcase
  endfunction

  task automatic check_word(input string name, input dma_word_t got, input dma_word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic check_istr(input string name, input istr_t got, input istr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s expected 0x%h got 0x%h at %0t", name, exp, got, $time);
    end
  endtask

  // Model steps on the same edge as the DUT, from the pre-edge inputs
  always @(posedge clk) begin : ref_model
    logic push_ok;
    logic pop_ok;
    if (!RESET_) begin
      m_cntr  = '0;
      m_acr   = '0;
      m_int_f = 1'b0;
      m_ints  = 1'b0;
      m_e_int = 1'b0;
      m_int_p = 1'b0;
      m_fifo.delete();
    end else begin
      push_ok = push && (m_fifo.size() < FIFO_DEPTH);
      pop_ok  = pop && (m_fifo.size() > 0);
      if (host_req.rd) begin
        exp_rd_q.push_back(expected_read(host_req.addr));
        exp_addr_q.push_back(host_req.addr);
      end
      // Clear beats set
      if (host_req.wr && (host_req.addr == CLR_INT_ADDR)) begin
        m_int_f = 1'b0;
        m_ints  = 1'b0;
        m_e_int = 1'b0;
        m_int_p = 1'b0;
      end else begin
        m_int_f = m_int_f | int_a;
        m_ints  = m_ints | int_a;
        m_e_int = m_e_int | int_a;
        m_int_p = m_int_p | (int_a & m_cntr.intena);
      end
      if (host_req.wr && (host_req.addr == CNTR_ADDR)) begin
        m_cntr.intena = host_req.wdata[0];
        m_cntr.dir    = host_req.wdata[1];
      end
      // One step per cycle with any accepted access
      if (host_req.wr && (host_req.addr == ACR_ADDR)) begin
        m_acr = host_req.wdata;
      end else if (push_ok || pop_ok) begin
        m_acr = m_acr + ACR_STEP;
      end
      if (pop_ok) begin
        void'(m_fifo.pop_front());
      end
      if (push_ok) begin
        m_fifo.push_back(push_data);
      end
    end
  end

  // Outputs sampled mid-cycle where they are settled
  always @(negedge clk) begin : compare
    dma_word_t         exp_word;
    logic [ADDR_W-1:0] exp_addr;
    if (RESET_) begin
      if (host_rsp.rd_valid) begin
        if (exp_rd_q.size() == 0) begin
          error_count++;
          $display("rd_valid seen with no read outstanding at %0t", $time);
        end else begin
          exp_word = exp_rd_q.pop_front();
          exp_addr = exp_addr_q.pop_front();
          if (exp_addr == ISTR_ADDR) begin
            check_istr("istr", istr_t'(host_rsp.rd_data[8:0]), istr_t'(exp_word[8:0]));
            check_word("rd_data[31:9]", host_rsp.rd_data >> 9, '0);
          end else begin
            check_word("rd_data", host_rsp.rd_data, exp_word);
          end
        end
      end
      if (pop && (m_fifo.size() > 0)) begin
        check_word("pop_data", pop_data, m_fifo[0]);
      end
      check_level("int_n", int_n, ~(m_cntr.intena & int_a));
      check_level("full", full, m_fifo.size() == FIFO_DEPTH);
      check_level("empty", empty, m_fifo.size() == 0);
      check_word("dma_addr", dma_addr, m_acr);
    end
  end

  task automatic host_write(input logic [ADDR_W-1:0] addr, input dma_word_t data);
    @(posedge clk);
    host_req.wr    <= 1'b1;
    host_req.addr  <= addr;
    host_req.wdata <= data;
    @(posedge clk);
    host_req.wr <= 1'b0;
  endtask

  // Issue a read and wait for its response with a bound
  task automatic host_read(input logic [ADDR_W-1:0] addr);
    int wait_cycles;
    @(posedge clk);
    host_req.rd   <= 1'b1;
    host_req.addr <= addr;
    @(posedge clk);
    host_req.rd <= 1'b0;
    wait_cycles = 0;
    @(negedge clk);
    while (!host_rsp.rd_valid && (wait_cycles < 4)) begin
      wait_cycles++;
      @(negedge clk);
    end
    if (!host_rsp.rd_valid) begin
      error_count++;
      $display("No read response for offset 0x%h at %0t", addr, $time);
    end
  endtask

  task automatic set_int_a(input logic level);
    @(posedge clk);
    int_a <= level;
  endtask

  // One DMA cycle, optionally with an ISTR read alongside
  task automatic dma_cycle(input logic do_push, input logic do_pop, input logic do_read);
    @(posedge clk);
    push          <= do_push;
    push_data     <= $urandom;
    pop           <= do_pop;
    host_req.rd   <= do_read;
    host_req.addr <= ISTR_ADDR;
  endtask

  task automatic dma_idle();
    @(posedge clk);
    push        <= 1'b0;
    pop         <= 1'b0;
    host_req.rd <= 1'b0;
  endtask

  task automatic test_reset_values();
    @(negedge clk);
    check_level("rd_valid", host_rsp.rd_valid, 1'b0);
    check_level("int_n", int_n, 1'b1);
    host_read(ISTR_ADDR);
    host_read(CNTR_ADDR);
    host_read(ACR_ADDR);
    host_read(CLR_INT_ADDR);
    host_read(5'h04);
  endtask

  task automatic test_reg_readback();
    repeat (8) begin
      host_write(CNTR_ADDR, $urandom);
      host_read(CNTR_ADDR);
      host_write(ACR_ADDR, $urandom);
      host_read(ACR_ADDR);
    end
  endtask

  task automatic test_int_gating();
    host_write(CNTR_ADDR, $urandom & 32'hffff_fffe);
    host_write(CLR_INT_ADDR, '0);
    set_int_a(1'b1);
    @(negedge clk);
    check_level("int_n", int_n, 1'b1);
    set_int_a(1'b0);
    host_read(ISTR_ADDR);
    host_write(CLR_INT_ADDR, '0);
    host_write(CNTR_ADDR, $urandom | 32'h1);
    set_int_a(1'b1);
    @(negedge clk);
    check_level("int_n", int_n, 1'b0);
    host_read(ISTR_ADDR);
    set_int_a(1'b0);
    @(negedge clk);
    check_level("int_n", int_n, 1'b1);
  endtask

  task automatic test_clear_flags();
    host_write(CLR_INT_ADDR, $urandom);
    host_read(ISTR_ADDR);
    repeat (5) @(posedge clk);
    host_read(ISTR_ADDR);
    // Single-cycle request sets the flags again
    set_int_a(1'b1);
    set_int_a(1'b0);
    host_read(ISTR_ADDR);
    host_write(CLR_INT_ADDR, '0);
    host_read(ISTR_ADDR);
  endtask

  // Push-heavy phase fills past full, pop-heavy phase drains past empty
  task automatic test_fifo_order();
    logic prev_read;
    logic do_read;
    prev_read = 1'b0;
    for (int i = 0; i < 80; i++) begin
      do_read = !prev_read && ($urandom_range(0, 5) == 0);
      if (i < 40) begin
        dma_cycle($urandom_range(0, 3) != 0, $urandom_range(0, 3) == 0, do_read);
      end else begin
        dma_cycle($urandom_range(0, 3) == 0, $urandom_range(0, 3) != 0, do_read);
      end
      prev_read = do_read;
    end
    dma_idle();
    host_read(ISTR_ADDR);
  endtask

  task automatic test_addr_advance();
    host_write(ACR_ADDR, $urandom);
    // Ten pushes in a row so some are dropped once full
    repeat (10) dma_cycle(1'b1, 1'b0, 1'b0);
    repeat (30) dma_cycle($urandom_range(0, 1), $urandom_range(0, 1), 1'b0);
    dma_idle();
    host_read(ACR_ADDR);
    // Host load in the same cycle as a FIFO transfer
    // Push and pop together always move at least one side
    @(posedge clk);
    push           <= 1'b1;
    push_data      <= $urandom;
    pop            <= 1'b1;
    host_req.wr    <= 1'b1;
    host_req.addr  <= ACR_ADDR;
    host_req.wdata <= $urandom;
    @(posedge clk);
    push        <= 1'b0;
    pop         <= 1'b0;
    host_req.wr <= 1'b0;
    host_read(ACR_ADDR);
  endtask

  task automatic report_test(input int num, input string name, input int start_errors);
    tests_run++;
    if (error_count == start_errors) begin
      $display("Test %0d (%s) ok", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d (%s) failed with %0d errors", num, name, error_count - start_errors);
    end
  endtask

  initial begin : main
    int start_errors;
    int seed_val;
    RESET_    = 1'b0;
    host_req  = '0;
    int_a     = 1'b0;
    push      = 1'b0;
    push_data = '0;
    pop       = 1'b0;
    seed_val  = $urandom(SEED);
    repeat (RESET_CYCLES) @(posedge clk);
    RESET_ <= 1'b1;
    @(posedge clk);
    start_errors = error_count;
    test_reset_values();
    report_test(1, "reset values", start_errors);
    start_errors = error_count;
    test_reg_readback();
    report_test(2, "register read-back", start_errors);
    start_errors = error_count;
    test_int_gating();
    report_test(3, "interrupt gating", start_errors);
    start_errors = error_count;
    test_clear_flags();
    report_test(4, "clearing flags", start_errors);
    start_errors = error_count;
    test_fifo_order();
    report_test(5, "FIFO order and status", start_errors);
    start_errors = error_count;
    test_addr_advance();
    repeat (4) @(posedge clk);
    if (exp_rd_q.size() != 0) begin
      error_count++;
      $display("%0d read responses never arrived", exp_rd_q.size());
    end
    report_test(6, "address advance", start_errors);
    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Bound of 200 cycles per test on top of reset
  initial begin : watchdog
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule : tb_sdmac_regs

// File: verilog/reg_access.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host register access
// Decodes host offsets into register strobes and
// returns registered read data one cycle after rd
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module reg_access (
  input  logic                                clk,
  input  logic                                RESET_,
  input  sdmac_bus_pkg::host_req_t            host_req,
  input  sdmac_reg_pkg::cntr_t                cntr,
  input  logic [sdmac_bus_pkg::DATA_W-1:0]    acr,
  input  sdmac_reg_pkg::istr_t                istr,
  output sdmac_reg_pkg::reg_strobe_t          strobe,
  output logic [sdmac_bus_pkg::DATA_W-1:0]    wdata,
  output sdmac_bus_pkg::host_rsp_t            host_rsp
);

  import sdmac_bus_pkg::*;
  import sdmac_reg_pkg::*;

  logic [DATA_W-1:0] rd_mux;
  logic              rd_valid_q;
  logic [DATA_W-1:0] rd_data_q;

  // Write data goes straight to the registers
  assign wdata = host_req.wdata;

  // Strobes, combinational so a write lands on the edge that samples wr
  assign strobe.cntr_wr = host_req.wr && (host_req.addr == CNTR_ADDR);
  assign strobe.acr_wr  = host_req.wr && (host_req.addr == ACR_ADDR);
  assign strobe.clr_int = host_req.wr && (host_req.addr == CLR_INT_ADDR);
  // ISTR read strobe also tells istr_reg to sample the FIFO status
  assign strobe.istr_rd = host_req.rd && (host_req.addr == ISTR_ADDR);

  // Read select
  // CLR_INT is write only and reads as zero like any unmapped offset
  always_comb begin
    rd_mux = '0;
    case (host_req.addr)
      CNTR_ADDR: rd_mux[$bits(cntr_t)-1:0] = cntr;
      ACR_ADDR:  rd_mux = acr;
      ISTR_ADDR: rd_mux[$bits(istr_t)-1:0] = istr;
      default:   rd_mux = '0;
    endcase
  end

  // Valid pulse one cycle after rd
  always_ff @(posedge clk) begin
    if (!RESET_) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= host_req.rd;
    end
  end

  // Read word captured on the rd edge only
  always_ff @(posedge clk) begin
    if (host_req.rd) begin
      rd_data_q <= rd_mux;
    end
  end

  assign host_rsp.rd_valid = rd_valid_q;
  assign host_rsp.rd_data  = rd_data_q;

  // Host never issues a read and a write together
  a_no_rd_wr: assert property (@(posedge clk) disable iff (!RESET_)
    !(host_req.rd && host_req.wr));

  // At most one register is touched per cycle
  a_strobe_onehot: assert property (@(posedge clk) disable iff (!RESET_)
    $onehot0(strobe));

endmodule : reg_access

// File: verilog/sdmac_regs_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDMAC host register block, top level
// Host decoder, CNTR, ACR, ISTR and the DMA FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module sdmac_regs_top #(
  parameter int FIFO_DEPTH = 8,
  parameter int ACR_STEP   = 4
) (
  input  logic                             clk,
  input  logic                             RESET_,
  // Host side
  input  sdmac_bus_pkg::host_req_t         host_req,
  output sdmac_bus_pkg::host_rsp_t         host_rsp,
  // Interrupt request in, active-low interrupt out
  input  logic                             int_a,
  output logic                             int_n,
  // DMA side
  input  logic                             push,
  input  sdmac_bus_pkg::dma_word_t         push_data,
  input  logic                             pop,
  output sdmac_bus_pkg::dma_word_t         pop_data,
  output logic                             full,
  output logic                             empty,
  output logic [sdmac_bus_pkg::DATA_W-1:0] dma_addr
);

  import sdmac_bus_pkg::*;
  import sdmac_reg_pkg::*;

  reg_strobe_t       strobe;
  logic [DATA_W-1:0] wdata;
  cntr_t             cntr;
  istr_t             istr;
  logic              xfer;

  // Decoder and read mux
  reg_access u_reg_access (
    .clk      (clk),
    .RESET_   (RESET_),
    .host_req (host_req),
    .cntr     (cntr),
    .acr      (dma_addr),
    .istr     (istr),
    .strobe   (strobe),
    .wdata    (wdata),
    .host_rsp (host_rsp)
  );

  cntr_reg u_cntr_reg (
    .clk     (clk),
    .RESET_  (RESET_),
    .cntr_wr (strobe.cntr_wr),
    .wdata   (wdata),
    .cntr    (cntr)
  );

  // Status flags and interrupt gate
  istr_reg u_istr_reg (
    .clk     (clk),
    .RESET_  (RESET_),
    .clr_int (strobe.clr_int),
    .istr_rd (strobe.istr_rd),
    .intena  (cntr.intena),
    .int_a   (int_a),
    .full    (full),
    .empty   (empty),
    .istr    (istr),
    .int_n   (int_n)
  );

  // ACR doubles as the DMA address output
  addr_counter #(
    .ACR_STEP (ACR_STEP)
  ) u_addr_counter (
    .clk    (clk),
    .RESET_ (RESET_),
    .acr_wr (strobe.acr_wr),
    .wdata  (wdata),
    .xfer   (xfer),
    .acr    (dma_addr)
  );

  dma_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dma_fifo (
    .clk       (clk),
    .RESET_    (RESET_),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty),
    .xfer      (xfer)
  );

endmodule : sdmac_regs_top
